// File: hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // major opcode, any code not listed here is undefined
  typedef enum logic [3:0] {
    OP_ADD = 4'b0000,  // saturating add
    OP_SUB = 4'b0001,  // saturating subtract
    OP_XOR = 4'b0010,
    OP_SLL = 4'b0100,
    OP_SRA = 4'b0101,
    OP_ROR = 4'b0110,
    OP_LLB = 4'b1010,  // load low byte, keep high byte of rd
    OP_LHB = 4'b1011   // load high byte, keep low byte of rd
  } opcode_e;

  // one instruction word, msb first
  typedef struct packed {
    opcode_e    opcode;
    logic [3:0] rd;
    logic [3:0] rs;      // high nibble of imm8 for llb/lhb
    logic [3:0] rt_imm;  // rt index, shift amount or low nibble of imm8
  } instr_t;

  // shifter mode taken from opcode[1:0]
  // 00 sll, 01 sra, 10 ror, 11 never issued
  typedef logic [1:0] shift_mode_t;

endpackage

`default_nettype wire

// File: hdl/datapath_pkg.sv
`default_nettype none

package datapath_pkg;

  typedef logic [15:0] word_t;     // data word
  typedef logic [3:0]  reg_idx_t;  // register index, r0..r15
  typedef logic [3:0]  shamt_t;    // shift amount 0..15

  // condition flags
  typedef struct packed {
    logic zero;
    logic overflow;  // only add/sub touch this one
    logic negative;
  } flags_t;

  // writeback, used for both the rf write port and the report
  typedef struct packed {
    reg_idx_t rd;
    word_t    data;
  } wb_t;

endpackage

`default_nettype wire

// File: hdl/shifter.sv
`timescale 1ns/1ps
`default_nettype none

module shifter
  import datapath_pkg::*;
  import isa_pkg::*;
(
  input  word_t       shift_in_i,
  input  shamt_t      shamt_i,
  input  shift_mode_t mode_i,      // opcode[1:0]
  output word_t       shift_out_o
);

  localparam int W      = $bits(word_t);
  localparam int STAGES = $bits(shamt_t);  // stages by 1, 2, 4, 8

  // stage 0 is the raw input, stage STAGES the final result
  word_t sll_stg [0:STAGES];
  word_t sra_stg [0:STAGES];
  word_t ror_stg [0:STAGES];

  assign sll_stg[0] = shift_in_i;
  assign sra_stg[0] = shift_in_i;
  assign ror_stg[0] = shift_in_i;

  for (genvar s = 0; s < STAGES; s++) begin : g_stage
    localparam int N = 2 ** s;

    // zero fill from the right
    assign sll_stg[s+1] = shamt_i[s] ? {sll_stg[s][W-1-N:0], {N{1'b0}}}
                                     : sll_stg[s];

    // sign bit fills every vacated position
    assign sra_stg[s+1] = shamt_i[s] ? {{N{sra_stg[s][W-1]}}, sra_stg[s][W-1:N]}
                                     : sra_stg[s];

    // bits leaving at the bottom come back in at the top
    assign ror_stg[s+1] = shamt_i[s] ? {ror_stg[s][N-1:0], ror_stg[s][W-1:N]}
                                     : ror_stg[s];
  end

  always_comb begin
    case (mode_i)
      2'b01:   shift_out_o = sra_stg[STAGES];
      2'b10:   shift_out_o = ror_stg[STAGES];
      default: shift_out_o = sll_stg[STAGES];  // 00, and 11 which is never used
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/sat_alu.sv
`timescale 1ns/1ps
`default_nettype none

module sat_alu
  import datapath_pkg::*;
  import isa_pkg::*;
(
  input  word_t   a_i,
  input  word_t   b_i,
  input  opcode_e op_i,
  output word_t   result_o,
  output logic    ovfl_o
);

  localparam int W = $bits(word_t);

  localparam word_t SAT_POS = {1'b0, {(W-1){1'b1}}};  // 0x7fff
  localparam word_t SAT_NEG = {1'b1, {(W-1){1'b0}}};  // 0x8000

  logic  sub;
  logic  is_arith;
  logic  ovfl;
  word_t b_eff;
  word_t sum;
  word_t sat_val;

  assign sub      = (op_i == OP_SUB);
  assign is_arith = (op_i == OP_ADD) || (op_i == OP_SUB);

  // a - b done as a + ~b + 1
  assign b_eff = sub ? ~b_i : b_i;
  assign sum   = a_i + b_eff + {{(W-1){1'b0}}, sub};

  // same operand signs but the sum flipped sign
  assign ovfl = (a_i[W-1] == b_eff[W-1]) && (sum[W-1] != a_i[W-1]);

  // direction of the overflow follows the sign of a
  assign sat_val = a_i[W-1] ? SAT_NEG : SAT_POS;

  always_comb begin
    case (op_i)
      OP_ADD,
      OP_SUB:  result_o = ovfl ? sat_val : sum;
      OP_XOR:  result_o = a_i ^ b_i;
      default: result_o = sum;  // result unused by the execute unit
    endcase
  end

  assign ovfl_o = is_arith && ovfl;  // xor never overflows

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
  import datapath_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  reg_idx_t rd_a_idx_i,
  input  reg_idx_t rd_b_idx_i,
  output word_t    rd_a_data_o,
  output word_t    rd_b_data_o,
  input  logic     wr_en_i,
  input  wb_t      wr_i
);

  localparam int NUM_REGS = 2 ** $bits(reg_idx_t);

  word_t regs [0:NUM_REGS-1];

  // written at the rising edge and never at r0
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en_i && (wr_i.rd != '0)) begin
      regs[wr_i.rd] <= wr_i.data;
    end
  end

  // combinational reads return the old value during a write cycle
  assign rd_a_data_o = regs[rd_a_idx_i];
  assign rd_b_data_o = regs[rd_b_idx_i];

  // a write aimed at r0 must leave it reading zero afterwards
  a_r0_zero: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (wr_en_i && (wr_i.rd == '0)) |=> (regs[0] == '0)
  ) else $error("r0 changed after a write to index 0");

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit
  import datapath_pkg::*;
  import isa_pkg::*;
(
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     instr_valid_i,
  input  instr_t   instr_i,
  output reg_idx_t rd_a_idx_o,
  output reg_idx_t rd_b_idx_o,
  input  word_t    rd_a_data_i,
  input  word_t    rd_b_data_i,
  output logic     wr_en_o,
  output wb_t      wr_o,
  output logic     wb_valid_o,
  output wb_t      wb_o,
  output flags_t   flags_o
);

  logic        defined;    // opcode is one of the eight implemented
  logic        use_shift;
  logic        use_load;
  logic        upd_zero;
  logic        upd_all;    // add/sub set every flag
  logic [7:0]  imm8;
  word_t       alu_res;
  logic        alu_ovfl;
  word_t       shift_res;
  word_t       load_res;
  word_t       result;
  shift_mode_t shift_mode;
  flags_t      flags_d;
  flags_t      flags_q;
  logic        wb_valid_q;
  wb_t         wb_q;

  // opcode decode
  always_comb begin
    defined   = 1'b1;
    use_shift = 1'b0;
    use_load  = 1'b0;
    upd_zero  = 1'b0;
    upd_all   = 1'b0;
    case (instr_i.opcode)
      OP_ADD, OP_SUB: begin
        upd_zero = 1'b1;
        upd_all  = 1'b1;
      end
      OP_XOR: begin
        upd_zero = 1'b1;
      end
      OP_SLL, OP_SRA, OP_ROR: begin
        use_shift = 1'b1;
        upd_zero  = 1'b1;
      end
      OP_LLB, OP_LHB: use_load = 1'b1;  // flags untouched
      default: defined = 1'b0;
    endcase
  end

  // port b reads rd on loads so the other byte survives
  assign rd_a_idx_o = instr_i.rs;
  assign rd_b_idx_o = use_load ? instr_i.rd : instr_i.rt_imm;

  sat_alu u_sat_alu (
    .a_i      (rd_a_data_i),
    .b_i      (rd_b_data_i),
    .op_i     (instr_i.opcode),
    .result_o (alu_res),
    .ovfl_o   (alu_ovfl)
  );

  assign shift_mode = instr_i.opcode[1:0];

  shifter u_shifter (
    .shift_in_i  (rd_a_data_i),
    .shamt_i     (instr_i.rt_imm),
    .mode_i      (shift_mode),
    .shift_out_o (shift_res)
  );

  assign imm8     = {instr_i.rs, instr_i.rt_imm};
  // opcode[0] picks lhb over llb
  assign load_res = instr_i.opcode[0] ? {imm8, rd_b_data_i[7:0]}
                                      : {rd_b_data_i[15:8], imm8};

  always_comb begin
    if (use_shift) begin
      result = shift_res;
    end else if (use_load) begin
      result = load_res;
    end else begin
      result = alu_res;
    end
  end

  assign wr_en_o = instr_valid_i && defined;
  assign wr_o    = '{rd: instr_i.rd, data: result};

  always_comb begin
    flags_d = flags_q;
    if (upd_zero) flags_d.zero = (result == '0);
    if (upd_all) begin
      flags_d.overflow = alu_ovfl;
      flags_d.negative = result[15];
    end
  end

  // report and flags land on the same edge as the rf write
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_valid_q <= 1'b0;
      wb_q       <= '0;
      flags_q    <= '0;
    end else begin
      wb_valid_q <= wr_en_o;
      if (wr_en_o) begin
        wb_q    <= wr_o;
        flags_q <= flags_d;
      end
    end
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_o       = wb_q;
  assign flags_o    = flags_q;

  // every report follows a strobe carrying a defined opcode
  a_wb_after_issue: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    wb_valid_o |-> ($past(instr_valid_i) && ($past(instr_i.opcode) inside
      {OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRA, OP_ROR, OP_LLB, OP_LHB}))
  ) else $error("wb_valid_o high without a defined issue");

  // the shifter never sees the unused mode
  a_no_mode_11: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (instr_valid_i && use_shift) |-> (shift_mode != 2'b11)
  ) else $error("shift issued with mode 11");

endmodule

`default_nettype wire

// File: hdl/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_top
  import datapath_pkg::*;
  import isa_pkg::*;
(
  input  logic   clk_i,
  input  logic   arst_n_i,
  input  logic   instr_valid_i,
  input  instr_t instr_i,
  output logic   wb_valid_o,
  output wb_t    wb_o,
  output flags_t flags_o
);

  reg_idx_t rd_a_idx;
  reg_idx_t rd_b_idx;
  word_t    rd_a_data;
  word_t    rd_b_data;
  logic     wr_en;
  wb_t      wr;      // write port, same value as the next report

  reg_file u_reg_file (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .rd_a_idx_i  (rd_a_idx),
    .rd_b_idx_i  (rd_b_idx),
    .rd_a_data_o (rd_a_data),
    .rd_b_data_o (rd_b_data),
    .wr_en_i     (wr_en),
    .wr_i        (wr)
  );

  exec_unit u_exec_unit (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .rd_a_idx_o    (rd_a_idx),
    .rd_b_idx_o    (rd_b_idx),
    .rd_a_data_i   (rd_a_data),
    .rd_b_data_i   (rd_b_data),
    .wr_en_o       (wr_en),
    .wr_o          (wr),
    .wb_valid_o    (wb_valid_o),
    .wb_o          (wb_o),
    .flags_o       (flags_o)
  );

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;  // 10 ns period
  end

  // reset held low for three rising edges, released on a falling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    arst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: testbench/exec_checker.sv
`timescale 1ns/1ps
`default_nettype none

module exec_checker
  import datapath_pkg::*;
  import isa_pkg::*;
(
  input  logic   clk_i,
  input  logic   arst_n_i,
  input  logic   instr_valid_i,
  input  instr_t instr_i,
  input  logic   wb_valid_i,
  input  wb_t    wb_i,
  input  flags_t flags_i,
  output int     check_cnt_o,
  output int     err_cnt_o
);

  word_t  regs [0:15];  // model register file
  logic   exp_valid;
  wb_t    exp_wb;
  flags_t exp_flags;
  bit     live;         // set once reset has been released
  int     checks = 0;
  int     errors = 0;

  assign check_cnt_o = checks;
  assign err_cnt_o   = errors;

  // one issued instruction, applied to the model at the rising edge
  task automatic apply(input logic v, input instr_t ins);
    word_t       a;
    word_t       b;
    word_t       d;
    word_t       res;
    int          s;
    logic [31:0] rot;
    logic        defined;
    flags_t      f;
    a       = regs[ins.rs];
    b       = regs[ins.rt_imm];
    d       = regs[ins.rd];
    f       = exp_flags;
    res     = '0;
    defined = 1'b1;
    case (ins.opcode)
      OP_ADD, OP_SUB: begin
        if (ins.opcode == OP_ADD) s = int'($signed(a)) + int'($signed(b));
        else s = int'($signed(a)) - int'($signed(b));
        if (s > 32767) res = 16'h7fff;  // clamp to the signed range
        else if (s < -32768) res = 16'h8000;
        else res = s[15:0];
        f.overflow = (s > 32767) || (s < -32768);
        f.negative = res[15];
      end
      OP_XOR: res = a ^ b;
      OP_SLL: res = a << ins.rt_imm;
      OP_SRA: res = word_t'($signed(a) >>> ins.rt_imm);
      OP_ROR: begin
        rot = {a, a} >> ins.rt_imm;
        res = rot[15:0];
      end
      OP_LLB: res = {d[15:8], ins.rs, ins.rt_imm};
      OP_LHB: res = {ins.rs, ins.rt_imm, d[7:0]};
      default: defined = 1'b0;
    endcase
    if (ins.opcode inside {OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRA, OP_ROR}) begin
      f.zero = (res == '0);
    end
    exp_valid = v && defined;
    if (exp_valid) begin
      exp_wb    = '{rd: ins.rd, data: res};
      exp_flags = f;
      if (ins.rd != '0) regs[ins.rd] = res;  // r0 stays zero
    end
  endtask

  task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] = '0;
      end
      exp_valid = 1'b0;
      exp_wb    = '0;
      exp_flags = '0;
    end else begin
      live = 1'b1;
      apply(instr_valid_i, instr_i);
    end
  end

  // outputs settle after the rising edge, so compare half a cycle later
  always @(negedge clk_i) begin
    if (live) begin
      compare("wb_valid_o", 16'(wb_valid_i), 16'(exp_valid));
      compare("wb_o.rd", 16'(wb_i.rd), 16'(exp_wb.rd));
      compare("wb_o.data", wb_i.data, exp_wb.data);
      compare("flags_o", 16'(flags_i), 16'(exp_flags));
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_top
  import datapath_pkg::*;
  import isa_pkg::*;
();

  logic        clk;
  logic        arst_n;
  logic        instr_valid;
  instr_t      instr;
  logic        wb_valid;
  wb_t         wb;
  flags_t      flags;
  int          check_cnt;
  int          err_cnt;
  logic [31:0] rng;
  bit          timed_out;

  tb_clock u_clock (.clk_o(clk), .arst_n_o(arst_n));

  exec_top dut_i (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .wb_valid_o    (wb_valid),
    .wb_o          (wb),
    .flags_o       (flags)
  );

  exec_checker u_checker (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .wb_valid_i    (wb_valid),
    .wb_i          (wb),
    .flags_i       (flags),
    .check_cnt_o   (check_cnt),
    .err_cnt_o     (err_cnt)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [15:0] next_rand16();
    rng = xorshift32(rng);
    return rng[15:0];
  endfunction

  task automatic issue(input instr_t ins);
    @(negedge clk);
    instr_valid = 1'b1;
    instr       = ins;
  endtask

  task automatic idle();
    @(negedge clk);
    instr_valid = 1'b0;
    instr       = instr_t'(next_rand16());  // junk fields must be ignored
  endtask

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (arst_n !== 1'b1 && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (arst_n !== 1'b1) begin
      $display("timed out waiting for reset release");
      timed_out = 1'b1;
    end
  endtask

  // let the last report land and be compared
  task automatic drain();
    int n;
    idle();
    n = 0;
    while (wb_valid === 1'b1 && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (wb_valid === 1'b1) begin
      $display("timed out waiting for the last writeback report");
      timed_out = 1'b1;
    end
    @(posedge clk);
  endtask

  task automatic end_run();
    $display("%0d checks, %0d errors", check_cnt, err_cnt);
    if (!timed_out && err_cnt == 0 && check_cnt > 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  endtask

  initial begin
    logic [15:0] r;
    instr_valid = 1'b0;
    instr       = '0;
    rng         = 32'd30069;
    timed_out   = 1'b0;
    wait_reset_release();
    if (!timed_out) begin
      // every register must read zero before the first load
      for (int i = 0; i < 16; i++) begin
        issue(instr_t'({OP_XOR, 4'd0, 4'(i), 4'(15 - i)}));
      end
      for (int i = 0; i < 16; i++) begin  // r0 included
        r = next_rand16();
        issue(instr_t'({OP_LLB, 4'(i), r[7:0]}));
        issue(instr_t'({OP_LHB, 4'(i), r[15:8]}));
      end
      for (int m = 0; m < 3; m++) begin   // sll, sra, ror by every amount
        for (int n = 0; n < 16; n++) begin
          r = next_rand16();
          issue(instr_t'({4'(4 + m), r[7:0], 4'(n)}));
        end
      end
      for (int i = 0; i < 2000; i++) begin
        r = next_rand16();
        if (r[1:0] != 2'b00) issue(instr_t'(next_rand16()));
        else idle();
      end
      drain();
    end
    end_run();
  end

endmodule

`default_nettype wire

// File: sources.f
hdl/isa_pkg.sv
hdl/datapath_pkg.sv
hdl/shifter.sv
hdl/sat_alu.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/exec_top.sv
testbench/tb_clock.sv
testbench/exec_checker.sv
testbench/tb_exec_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
